/* include/ram_loader_params.svh */
`ifndef RAM_LOADER_PARAMS_SVH
`define RAM_LOADER_PARAMS_SVH

// ======================================================================
// bus widths
// ======================================================================

// byte address into system ram
`define RL_ADDR_W 27
`define RL_DATA_W 32
// one host download word
`define RL_HALF_W 16
`define RL_BE_W 4

// ======================================================================
// download regions
// ======================================================================

`define RL_BIOS_START 2097152
`define RL_EXE_START 4194304
// cheat code download, never written to ram
`define RL_CODE_INDEX 255

// pending write slots, also the credit count
`define RL_FIFO_DEPTH 4

`endif

/* hdl/ram_loader_pkg.sv */
`include "ram_loader_params.svh"

package ram_loader_pkg;

	// host download bus, 53 bits
	typedef struct packed {
		logic                  download;
		logic [7:0]            index;
		logic [`RL_ADDR_W-1:0] addr;
		logic [`RL_HALF_W-1:0] dout;
		logic                  wr;
	} ioctl_bus_t;

	// one ram write, 63 bits
	// shared by download queue and core path
	typedef struct packed {
		logic [`RL_ADDR_W-1:0] addr;
		logic [`RL_DATA_W-1:0] data;
		logic [`RL_BE_W-1:0]   be;
	} mem_wr_t;

	// which base the download lands on
	typedef enum logic {
		region_bios = 1'b0,
		region_exe  = 1'b1
	} dl_region_e;

endpackage

/* hdl/ioctl_word_packer.sv */
`timescale 1ns/1ps
`include "ram_loader_params.svh"

module ioctl_word_packer #(
	parameter int DEPTH = `RL_FIFO_DEPTH
) (
	input  logic                       clk_1x,
	input  logic                       rst,
	input  ram_loader_pkg::ioctl_bus_t ioctl,
	output logic                       ioctl_wait,
	output logic                       push,
	output ram_loader_pkg::mem_wr_t    push_data,
	input  logic                       credit,
	output logic                       dl_busy,
	output ram_loader_pkg::dl_region_e dl_region
);
	import ram_loader_pkg::*;

	localparam int CNT_W = $clog2(DEPTH + 1);

	logic                  bios_sel;
	logic                  exe_sel;
	logic                  half_hi;
	logic [`RL_ADDR_W-1:0] region_base;
	logic [`RL_HALF_W-1:0] low_q;
	logic [`RL_ADDR_W-1:0] addr_q;
	logic [CNT_W-1:0]      credit_cnt;
	logic [CNT_W-1:0]      credit_nxt;

	// ======================================================================
	// index decode
	// ======================================================================

	// index 0 is bios, 1..254 executable, 255 dropped
	assign bios_sel = ioctl.download && (ioctl.index == 8'd0);
	assign exe_sel  = ioctl.download && (ioctl.index != 8'd0)
		&& (ioctl.index != 8'(`RL_CODE_INDEX));
	// address bit 1 marks the upper half of a pair
	assign half_hi = ioctl.addr[1];
	assign region_base = bios_sel ? `RL_ADDR_W'(`RL_BIOS_START) : `RL_ADDR_W'(`RL_EXE_START);

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			dl_busy   <= 1'b0;
			dl_region <= region_bios;
			push      <= 1'b0;
		end else begin
			// push and dl_busy come from the same cycle, never apart
			dl_busy <= bios_sel | exe_sel;
			// region sticks after the download ends
			if (bios_sel)
				dl_region <= region_bios;
			else if (exe_sel)
				dl_region <= region_exe;
			push <= (bios_sel | exe_sel) & ioctl.wr & half_hi;
		end
	end

	// ======================================================================
	// word pairing
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if ((bios_sel | exe_sel) && ioctl.wr) begin
			if (!half_hi) begin
				// low half first, based address with it
				low_q  <= ioctl.dout;
				addr_q <= ioctl.addr + region_base;
			end else begin
				push_data.addr <= addr_q;
				push_data.data <= {ioctl.dout, low_q};
				push_data.be   <= '1;
			end
		end
	end

	// ======================================================================
	// credits
	// ======================================================================

	always_comb begin
		credit_nxt = credit_cnt;
		if (push)
			credit_nxt = credit_nxt - 1'b1;
		if (credit)
			credit_nxt = credit_nxt + 1'b1;
	end

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			credit_cnt <= CNT_W'(DEPTH);
			ioctl_wait <= 1'b0;
		end else begin
			credit_cnt <= credit_nxt;
			// hold the host off once the last slot is spent
			ioctl_wait <= (credit_nxt == '0);
		end
	end

endmodule

/* hdl/credit_fifo.sv */
`timescale 1ns/1ps
`include "ram_loader_params.svh"

module credit_fifo #(
	parameter int DEPTH = `RL_FIFO_DEPTH
) (
	input  logic                    clk_1x,
	input  logic                    rst,
	input  logic                    push,
	input  ram_loader_pkg::mem_wr_t push_data,
	output ram_loader_pkg::mem_wr_t head,
	output logic                    head_valid,
	input  logic                    pop,
	output logic                    credit
);
	import ram_loader_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	mem_wr_t          slot_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	// wrap at DEPTH, works for any depth
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign head       = slot_q[rd_ptr];
	// pop on empty is ignored
	assign do_pop     = pop & head_valid;
	// one slot back to the producer per pop
	assign credit     = do_pop;

	// ======================================================================
	// storage
	// ======================================================================

	// producer holds credits, so push never lands on a full queue
	always_ff @(posedge clk_1x) begin
		if (push)
			slot_q[wr_ptr] <= push_data;
	end

	// ======================================================================
	// pointers and occupancy
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* hdl/sdram_write_port.sv */
`timescale 1ns/1ps

module sdram_write_port (
	input  logic                       clk_1x,
	input  logic                       rst,
	input  ram_loader_pkg::mem_wr_t    head,
	input  logic                       head_valid,
	output logic                       pop,
	input  logic                       dl_busy,
	input  ram_loader_pkg::dl_region_e dl_region,
	input  ram_loader_pkg::mem_wr_t    core_wr,
	input  logic                       core_req,
	output logic                       core_ack,
	output ram_loader_pkg::mem_wr_t    mem_wr,
	output logic                       mem_req,
	input  logic                       mem_ack,
	output logic                       load_exe
);
	import ram_loader_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_dl_write,
		st_core_write
	} port_state_e;

	port_state_e state;
	logic        dl_owned;
	logic        dl_owned_q;

	// ======================================================================
	// ack routing
	// ======================================================================

	// pop and credit land in the ack cycle
	assign pop      = (state == st_dl_write) & mem_ack;
	assign core_ack = (state == st_core_write) & mem_ack;

	// ======================================================================
	// channel owner
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			state   <= st_idle;
			mem_req <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					// queued download writes first
					if (head_valid) begin
						state   <= st_dl_write;
						mem_req <= 1'b1;
					end else if (core_req && !dl_busy) begin
						state   <= st_core_write;
						mem_req <= 1'b1;
					end
				end
				st_dl_write, st_core_write: begin
					// request held until the ram answers
					if (mem_ack) begin
						state   <= st_idle;
						mem_req <= 1'b0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// sampled only while idle, stays put for the whole request
	always_ff @(posedge clk_1x) begin
		if (state == st_idle)
			mem_wr <= head_valid ? head : core_wr;
	end

	// ======================================================================
	// exe start
	// ======================================================================

	// download owns the channel until busy, queue and last write are all gone
	assign dl_owned = dl_busy | head_valid | (state == st_dl_write);

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			dl_owned_q <= 1'b0;
			load_exe   <= 1'b0;
		end else begin
			dl_owned_q <= dl_owned;
			// falling edge of ownership, exe region only
			load_exe   <= dl_owned_q & ~dl_owned & (dl_region == region_exe);
		end
	end

endmodule

/* hdl/ram_loader.sv */
`timescale 1ns/1ps
`include "ram_loader_params.svh"

module ram_loader (
	input  logic                       clk_1x,
	input  logic                       rst,
	input  ram_loader_pkg::ioctl_bus_t ioctl,
	output logic                       ioctl_wait,
	input  ram_loader_pkg::mem_wr_t    core_wr,
	input  logic                       core_req,
	output logic                       core_ack,
	output ram_loader_pkg::mem_wr_t    mem_wr,
	output logic                       mem_req,
	input  logic                       mem_ack,
	output logic                       load_exe
);
	import ram_loader_pkg::*;

	// packer to queue
	logic       push;
	mem_wr_t    push_data;
	logic       credit;
	// queue to port
	mem_wr_t    head;
	logic       head_valid;
	logic       pop;
	// packer to port
	logic       dl_busy;
	dl_region_e dl_region;

	ioctl_word_packer #(.DEPTH(`RL_FIFO_DEPTH)) packer_i (
		.clk_1x(clk_1x), .rst(rst), .ioctl(ioctl), .ioctl_wait(ioctl_wait),
		.push(push), .push_data(push_data), .credit(credit),
		.dl_busy(dl_busy), .dl_region(dl_region)
	);

	credit_fifo #(.DEPTH(`RL_FIFO_DEPTH)) fifo_i (
		.clk_1x(clk_1x), .rst(rst), .push(push), .push_data(push_data),
		.head(head), .head_valid(head_valid), .pop(pop), .credit(credit)
	);

	sdram_write_port port_i (
		.clk_1x(clk_1x), .rst(rst), .head(head), .head_valid(head_valid), .pop(pop),
		.dl_busy(dl_busy), .dl_region(dl_region),
		.core_wr(core_wr), .core_req(core_req), .core_ack(core_ack),
		.mem_wr(mem_wr), .mem_req(mem_req), .mem_ack(mem_ack), .load_exe(load_exe)
	);

endmodule

/* tb/ram_loader_props.sv */
`timescale 1ns/1ps
`include "ram_loader_params.svh"

module ram_loader_props (
	input logic                    clk_1x,
	input logic                    rst,
	input ram_loader_pkg::mem_wr_t mem_wr,
	input logic                    mem_req,
	input logic                    mem_ack,
	input logic                    load_exe,
	input logic                    ioctl_wait,
	input logic                    push,
	input logic                    credit
);
	localparam int CNT_W = $clog2(`RL_FIFO_DEPTH + 1);

	logic [CNT_W-1:0] credits;
	int               fail_count = 0;

	// free slots as the producer should see them
	always_ff @(posedge clk_1x) begin
		if (rst)
			credits <= CNT_W'(`RL_FIFO_DEPTH);
		else
			credits <= credits - CNT_W'(push) + CNT_W'(credit);
	end

	// request held with a stable payload until the ram answers
	assert property (@(posedge clk_1x) disable iff (rst)
		mem_req && !mem_ack |=> mem_req && $stable(mem_wr))
		else begin
			fail_count++;
			$error("mem_req or mem_wr changed before mem_ack");
		end

	assert property (@(posedge clk_1x) disable iff (rst) load_exe |=> !load_exe)
		else begin
			fail_count++;
			$error("load_exe high for more than one cycle");
		end

	// host must be held off once the slots run out
	assert property (@(posedge clk_1x) disable iff (rst) (credits == '0) |-> ioctl_wait)
		else begin
			fail_count++;
			$error("ioctl_wait low with no credits left");
		end

	assert property (@(posedge clk_1x) disable iff (rst) push |-> (credits != '0))
		else begin
			fail_count++;
			$error("push issued with no credits left");
		end

endmodule

bind ram_loader ram_loader_props props_i (.*);

/* tb/ram_loader_tb.sv */
`timescale 1ns/1ps
`include "ram_loader_params.svh"

module ram_loader_tb;
	import ram_loader_pkg::*;

	localparam int WAIT_LIMIT = 2000;

	logic       clk_1x = 1'b0;
	logic       rst = 1'b1;
	ioctl_bus_t ioctl;
	logic       ioctl_wait;
	mem_wr_t    core_wr;
	logic       core_req;
	logic       core_ack;
	mem_wr_t    mem_wr;
	logic       mem_req;
	logic       mem_ack = 1'b0;
	logic       load_exe;

	int      seed = 32'hf287;
	int      rnd;
	int      max_delay = 3;
	int      ack_delay = 0;
	logic    ack_pending = 1'b0;
	int      errors = 0;
	int      timeouts = 0;
	int      exe_pulses = 0;
	int      exe_log_size = 0;
	int      wait_cycles = 0;
	int      core_acks = 0;
	int      lone_core_acks = 0;
	mem_wr_t exp_q[$];
	mem_wr_t mem_log[$];

	always #2 clk_1x = ~clk_1x;

	ram_loader dut_i (
		.clk_1x(clk_1x), .rst(rst), .ioctl(ioctl), .ioctl_wait(ioctl_wait),
		.core_wr(core_wr), .core_req(core_req), .core_ack(core_ack),
		.mem_wr(mem_wr), .mem_req(mem_req), .mem_ack(mem_ack), .load_exe(load_exe)
	);

	// ======================================================================
	// memory model and monitors
	// ======================================================================

	// random ack latency with a one cycle ack
	always @(negedge clk_1x) begin
		if (rst) begin
			mem_ack     <= 1'b0;
			ack_pending <= 1'b0;
		end else if (mem_ack) begin
			mem_ack <= 1'b0;
		end else if (mem_req && !ack_pending) begin
			rnd = $random(seed);
			ack_pending <= 1'b1;
			ack_delay   <= (rnd & 32'h7fffffff) % (max_delay + 1);
		end else if (ack_pending) begin
			if (ack_delay == 0) begin
				mem_ack     <= 1'b1;
				ack_pending <= 1'b0;
			end else begin
				ack_delay <= ack_delay - 1;
			end
		end
	end

	// sampled where the dut samples
	always @(posedge clk_1x) begin
		if (mem_req === 1'b1 && mem_ack === 1'b1)
			mem_log.push_back(mem_wr);
		if (core_ack === 1'b1) begin
			core_acks++;
			// core_ack has to ride on the memory ack
			if (!(mem_req === 1'b1 && mem_ack === 1'b1))
				lone_core_acks++;
		end
		if (load_exe === 1'b1) begin
			exe_pulses++;
			exe_log_size = mem_log.size();
		end
		if (ioctl_wait === 1'b1)
			wait_cycles++;
	end

	// ======================================================================
	// helpers
	// ======================================================================

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (expected === actual) else begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic step_cycles(input int n);
		repeat (n) @(negedge clk_1x);
	endtask

	// payload tied to the full target address
	function automatic logic [31:0] word_pattern(input logic [`RL_ADDR_W-1:0] addr,
		input logic [7:0] index);
		return (32'(addr) * 32'h9e3779b1) ^ {24'h0, index};
	endfunction

	task automatic send_word(input logic [`RL_ADDR_W-1:0] addr, input logic [15:0] word);
		int t;
		t = 0;
		while (ioctl_wait && t < WAIT_LIMIT) begin
			@(negedge clk_1x);
			t++;
		end
		assert (!ioctl_wait) else begin
			timeouts++;
			$display("Timeout: host held off by ioctl_wait for too long");
		end
		ioctl.addr = addr;
		ioctl.dout = word;
		ioctl.wr   = 1'b1;
		@(negedge clk_1x);
		ioctl.wr = 1'b0;
	endtask

	task automatic run_download(input logic [7:0] index, input int pairs);
		logic [`RL_ADDR_W-1:0] base;
		logic [`RL_ADDR_W-1:0] offset;
		logic [31:0]           data;
		int                    k;
		// index 0 lands on bios and the rest on the exe region
		base = (index == 8'd0) ? `RL_ADDR_W'(`RL_BIOS_START) : `RL_ADDR_W'(`RL_EXE_START);
		ioctl.download = 1'b1;
		ioctl.index    = index;
		for (k = 0; k < pairs; k++) begin
			offset = `RL_ADDR_W'(4 * k);
			data   = word_pattern(base + offset, index);
			// low half first
			send_word(offset, data[15:0]);
			send_word(offset + `RL_ADDR_W'(2), data[31:16]);
			if (index != 8'(`RL_CODE_INDEX))
				exp_q.push_back({base + offset, data, 4'hf});
		end
		ioctl.download = 1'b0;
	endtask

	task automatic wait_drain(input int count, input string name);
		int t;
		t = 0;
		while ((mem_log.size() < count || mem_req) && t < WAIT_LIMIT) begin
			@(negedge clk_1x);
			t++;
		end
		assert (mem_log.size() >= count && !mem_req) else begin
			timeouts++;
			$display("Timeout: %s writes did not all reach memory", name);
		end
		step_cycles(4);
	endtask

	task automatic check_log(input string name);
		int i;
		check_value({name, " write count"}, 64'(exp_q.size()), 64'(mem_log.size()));
		for (i = 0; i < exp_q.size() && i < mem_log.size(); i++)
			check_value($sformatf("%s write %0d", name, i), 64'(exp_q[i]), 64'(mem_log[i]));
		exp_q.delete();
		mem_log.delete();
	endtask

	task automatic core_write(input mem_wr_t w, input string name);
		int t;
		int acks0;
		int lone0;
		acks0    = core_acks;
		lone0    = lone_core_acks;
		core_wr  = w;
		core_req = 1'b1;
		t = 0;
		while (core_acks == acks0 && t < WAIT_LIMIT) begin
			@(negedge clk_1x);
			t++;
		end
		core_req = 1'b0;
		assert (core_acks != acks0) else begin
			timeouts++;
			$display("Timeout: %s request never acknowledged", name);
		end
		// ack and the memory write share one cycle
		if (mem_log.size() > 0)
			check_value({name, " data"}, 64'(w), 64'(mem_log[$]));
		// one request, one single cycle ack
		step_cycles(2);
		check_value({name, " ack count"}, 64'd1, 64'(core_acks - acks0));
		check_value({name, " ack without mem_ack"}, 64'd0, 64'(lone_core_acks - lone0));
		exp_q.push_back(w);
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================

	task automatic check_reset_state();
		check_value("reset mem_req", 64'd0, 64'(mem_req));
		check_value("reset core_ack", 64'd0, 64'(core_ack));
		check_value("reset ioctl_wait", 64'd0, 64'(ioctl_wait));
		check_value("reset load_exe", 64'd0, 64'(load_exe));
		step_cycles(8);
		check_value("reset writes", 64'd0, 64'(mem_log.size()));
	endtask

	task automatic bios_download();
		int pulses0;
		pulses0 = exe_pulses;
		run_download(8'd0, 6);
		wait_drain(exp_q.size(), "bios");
		check_log("bios");
		check_value("bios load_exe", 64'd0, 64'(exe_pulses - pulses0));
	endtask

	task automatic exe_download();
		int pulses0;
		int t;
		pulses0   = exe_pulses;
		max_delay = 5;
		run_download(8'd1, 5);
		wait_drain(exp_q.size(), "exe");
		t = 0;
		while (exe_pulses == pulses0 && t < WAIT_LIMIT) begin
			@(negedge clk_1x);
			t++;
		end
		assert (exe_pulses != pulses0) else begin
			timeouts++;
			$display("Timeout: no load_exe pulse after the exe download");
		end
		step_cycles(10);
		check_value("exe load_exe", 64'd1, 64'(exe_pulses - pulses0));
		// pulse only once every write is in
		check_value("exe writes before load_exe", 64'(exp_q.size()), 64'(exe_log_size));
		check_log("exe");
	endtask

	task automatic back_pressure();
		int waits0;
		waits0    = wait_cycles;
		max_delay = 20;
		run_download(8'd0, 12);
		wait_drain(exp_q.size(), "back_pressure");
		check_value("back_pressure ioctl_wait seen", 64'd1, 64'(wait_cycles > waits0));
		check_log("back_pressure");
		max_delay = 3;
	endtask

	task automatic core_arbitration();
		core_write({27'h1230, 32'hdead_beef, 4'b0011}, "core idle a");
		core_write({27'h7f_fff0, 32'h0123_4567, 4'b1000}, "core idle b");
		check_log("core idle");
		// core waits out a download in progress
		fork
			run_download(8'd0, 6);
			begin
				step_cycles(3);
				core_write({27'h40, 32'hcafe_f00d, 4'b0110}, "core during download");
				check_value("core after drain", 64'd7, 64'(mem_log.size()));
			end
		join
		wait_drain(exp_q.size(), "core during download");
		check_log("core during download");
	endtask

	task automatic ignored_code_index();
		int pulses0;
		int waits0;
		pulses0 = exe_pulses;
		waits0  = wait_cycles;
		run_download(8'(`RL_CODE_INDEX), 6);
		step_cycles(20);
		check_value("code index ioctl_wait", 64'd0, 64'(wait_cycles - waits0));
		check_value("code index load_exe", 64'd0, 64'(exe_pulses - pulses0));
		check_log("code index");
	endtask

	initial begin
		ioctl    = '0;
		core_wr  = '0;
		core_req = 1'b0;
		rst      = 1'b1;
		repeat (3) @(negedge clk_1x);
		rst = 1'b0;
		check_reset_state();
		bios_download();
		exe_download();
		back_pressure();
		core_arbitration();
		ignored_code_index();
		step_cycles(5);
		$display("Checks failed: %0d, timeouts: %0d, property failures: %0d",
			errors, timeouts, dut_i.props_i.fail_count);
		if (errors == 0 && timeouts == 0 && dut_i.props_i.fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* ram_loader.f */
+incdir+include
hdl/ram_loader_pkg.sv
hdl/ioctl_word_packer.sv
hdl/credit_fifo.sv
hdl/sdram_write_port.sv
hdl/ram_loader.sv
tb/ram_loader_props.sv
tb/ram_loader_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ram_loader_tb
FILELIST  ?= ram_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
